// File: cachePkg.sv
// Instruction cache shared definitions
`default_nettype none

package cachePkg;

    // Word and address widths
    localparam int wordBits = 16;
    localparam int addrBits = 16;

    // Address split: tag | line index | word offset
    localparam int tagBits    = 2;
    localparam int indexBits  = 11;
    localparam int offsetBits = 3;

    // Words per cache line
    localparam int lineWords = 8;

    // One instruction word
    typedef logic [wordBits-1:0] word_t;

    // Word address into main memory
    typedef logic [addrBits-1:0] addr_t;

    // Upper address bits kept per line
    typedef logic [tagBits-1:0] tag_t;

    // Line select, 2048 lines
    typedef logic [indexBits-1:0] index_t;

    // Word position inside a line
    typedef logic [offsetBits-1:0] offset_t;

    // Controller states
    // Idle waits for a request, Lookup compares the tag,
    // WriteBack flushes a dirty victim, Refill loads the new line,
    // Respond returns ack to the processor
    typedef enum logic [2:0] {
        Idle,
        Lookup,
        WriteBack,
        Refill,
        Respond
    } ctrlState_t;

endpackage

`default_nettype wire

// File: mainMemory.sv
// Main memory model
`default_nettype none

module mainMemory (
    input  logic            clk,
    input  logic            reset,
    input  logic            memCyc,
    input  logic            memStb,
    input  logic            memWe,
    input  cachePkg::addr_t memAdr,
    input  cachePkg::word_t memDatWr,
    output cachePkg::word_t memDatRd,
    output logic            memAck
);
    import cachePkg::*;

    // 64K words
    word_t memArray [2**addrBits];

    logic beatStart;

    // New beat when strobed and not already acknowledging
    assign beatStart = memCyc && memStb && !memAck;

    // Everything reads as zero at start
    initial begin
        for (int i = 0; i < 2**addrBits; i++) begin
            memArray[i] = '0;
        end
    end

    // Store on the accepted beat, read data returns with ack
    always @(posedge clk) begin
        if (beatStart) begin
            if (memWe) begin
                memArray[memAdr] <= memDatWr;
            end
            memDatRd <= memArray[memAdr];
        end
    end

    // One cycle ack pulse per beat
    always_ff @(posedge clk) begin
        if (reset) begin
            memAck <= 1'b0;
        end else begin
            memAck <= beatStart;
        end
    end

endmodule

`default_nettype wire

// File: cacheStorage.sv
// Cache line storage
`default_nettype none

module cacheStorage (
    input  logic              clk,
    input  logic              reset,
    input  cachePkg::index_t  index,
    input  cachePkg::offset_t offset,
    input  logic              wordWrEn,
    input  cachePkg::word_t   wordWrData,
    input  logic              tagWrEn,
    input  cachePkg::tag_t    newTag,
    input  logic              setDirty,
    output cachePkg::tag_t    lineTag,
    output logic              lineValid,
    output logic              lineDirty,
    output cachePkg::word_t   readWord
);
    import cachePkg::*;

    // Data words, addressed by {index, offset}
    word_t dataMem [2**indexBits * lineWords];

    // Per line tag
    tag_t tagMem [2**indexBits];

    // Per line status
    logic [2**indexBits-1:0] validBits;
    logic [2**indexBits-1:0] dirtyBits;

    // Word write and registered read
    // A read in the write cycle returns the old word
    always_ff @(posedge clk) begin
        if (wordWrEn) begin
            dataMem[{index, offset}] <= wordWrData;
        end
        readWord <= dataMem[{index, offset}];
    end

    // Tag update on line replacement
    always_ff @(posedge clk) begin
        if (tagWrEn) begin
            tagMem[index] <= newTag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            validBits <= '0;
            dirtyBits <= '0;
        end else begin
            if (tagWrEn) begin
                // Fresh line, clean
                validBits[index] <= 1'b1;
                dirtyBits[index] <= 1'b0;
            end
            // Write hit marks the line modified
            if (setDirty) begin
                dirtyBits[index] <= 1'b1;
            end
        end
    end

    // Lookup outputs straight from the index
    assign lineTag   = tagMem[index];
    assign lineValid = validBits[index];
    assign lineDirty = dirtyBits[index];

endmodule

`default_nettype wire

// File: cacheController.sv
// Cache lookup and line transfer controller
`default_nettype none

module cacheController (
    input  logic              clk,
    input  logic              reset,
    // Processor side, Wishbone classic slave
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  cachePkg::addr_t   adr,
    input  cachePkg::word_t   datWr,
    output cachePkg::word_t   datRd,
    output logic              ack,
    output logic              hit,
    // Line storage side
    output cachePkg::index_t  index,
    output cachePkg::offset_t offset,
    input  cachePkg::tag_t    lineTag,
    input  logic              lineValid,
    input  logic              lineDirty,
    input  cachePkg::word_t   readWord,
    output logic              wordWrEn,
    output cachePkg::word_t   wordWrData,
    output logic              tagWrEn,
    output cachePkg::tag_t    newTag,
    output logic              setDirty,
    // Memory side, Wishbone classic master
    output logic              memCyc,
    output logic              memStb,
    output logic              memWe,
    output cachePkg::addr_t   memAdr,
    output cachePkg::word_t   memDatWr,
    input  cachePkg::word_t   memDatRd,
    input  logic              memAck
);
    import cachePkg::*;

    ctrlState_t state;

    // Captured request
    tag_t    reqTag;
    index_t  reqIndex;
    offset_t reqOffset;
    logic    reqWe;
    word_t   reqData;

    // Beat position within a line transfer
    offset_t beat;
    // Set once this request has gone through a refill
    logic    refilled;
    logic    hitReg;

    logic    tagMatch;
    logic    lastBeat;
    logic    lookupHit;

    // Valid line with the requested tag
    assign tagMatch  = lineValid && (lineTag == reqTag);
    assign lookupHit = (state == Lookup) && tagMatch;
    // Eighth word acknowledged
    assign lastBeat  = memAck && (beat == offset_t'(lineWords - 1));

    // Request capture, one access at a time
    always_ff @(posedge clk) begin
        if (state == Idle && cyc && stb) begin
            {reqTag, reqIndex, reqOffset} <= adr;
            reqWe   <= we;
            reqData <= datWr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= Idle;
            beat     <= '0;
            refilled <= 1'b0;
            hitReg   <= 1'b0;
        end else begin
            case (state)
                Idle: begin
                    if (cyc && stb) begin
                        refilled <= 1'b0;
                        state    <= Lookup;
                    end
                end
                Lookup: begin
                    if (tagMatch) begin
                        // Second lookup after a refill always matches
                        hitReg <= !refilled;
                        state  <= Respond;
                    end else if (lineDirty) begin
                        state <= WriteBack;
                    end else begin
                        state <= Refill;
                    end
                end
                WriteBack: begin
                    if (memAck) begin
                        beat <= beat + 1'b1;
                        if (lastBeat) begin
                            state <= Refill;
                        end
                    end
                end
                Refill: begin
                    if (memAck) begin
                        beat <= beat + 1'b1;
                        if (lastBeat) begin
                            refilled <= 1'b1;
                            state    <= Lookup;
                        end
                    end
                end
                Respond: begin
                    state <= Idle;
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    // Storage address
    // Data is registered, so the next word is presented one cycle early
    assign index = reqIndex;

    always_comb begin
        if (lookupHit) begin
            offset = reqOffset;
        end else if (state == WriteBack && memAck) begin
            // Prefetch the following victim word
            offset = offset_t'(beat + 1'b1);
        end else begin
            offset = beat;
        end
    end

    // Word writes come from a write hit or a refill beat
    assign wordWrEn   = (lookupHit && reqWe) || (state == Refill && memAck);
    assign wordWrData = (state == Refill) ? memDatRd : reqData;
    assign setDirty   = lookupHit && reqWe;

    // New tag lands with the last refill word
    assign tagWrEn = (state == Refill) && lastBeat;
    assign newTag  = reqTag;

    // Memory bus, held for the whole line
    assign memCyc   = (state == WriteBack) || (state == Refill);
    assign memStb   = memCyc;
    assign memWe    = (state == WriteBack);
    // Victim address uses the stored tag
    assign memAdr   = {(state == WriteBack) ? lineTag : reqTag, reqIndex, beat};
    assign memDatWr = readWord;

    // Processor response
    assign ack   = (state == Respond) && cyc && stb;
    assign hit   = hitReg;
    assign datRd = readWord;

endmodule

`default_nettype wire

// File: instructionL1.sv
// Instruction cache top level
`default_nettype none

module instructionL1 (
    input  logic              clk,
    input  logic              reset,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  cachePkg::addr_t   adr,
    input  cachePkg::word_t   datWr,
    output cachePkg::word_t   datRd,
    output logic              ack,
    output logic              hit
);

    // Controller to line storage
    cachePkg::index_t  index;
    cachePkg::offset_t offset;
    cachePkg::tag_t    lineTag;
    logic              lineValid;
    logic              lineDirty;
    cachePkg::word_t   readWord;
    logic              wordWrEn;
    cachePkg::word_t   wordWrData;
    logic              tagWrEn;
    cachePkg::tag_t    newTag;
    logic              setDirty;

    // Controller to main memory, Wishbone classic
    logic              memCyc;
    logic              memStb;
    logic              memWe;
    cachePkg::addr_t   memAdr;
    cachePkg::word_t   memDatWr;
    cachePkg::word_t   memDatRd;
    logic              memAck;

    cacheController ctrl (
        .clk        (clk),
        .reset      (reset),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .datWr      (datWr),
        .datRd      (datRd),
        .ack        (ack),
        .hit        (hit),
        .index      (index),
        .offset     (offset),
        .lineTag    (lineTag),
        .lineValid  (lineValid),
        .lineDirty  (lineDirty),
        .readWord   (readWord),
        .wordWrEn   (wordWrEn),
        .wordWrData (wordWrData),
        .tagWrEn    (tagWrEn),
        .newTag     (newTag),
        .setDirty   (setDirty),
        .memCyc     (memCyc),
        .memStb     (memStb),
        .memWe      (memWe),
        .memAdr     (memAdr),
        .memDatWr   (memDatWr),
        .memDatRd   (memDatRd),
        .memAck     (memAck)
    );

    cacheStorage storage (
        .clk        (clk),
        .reset      (reset),
        .index      (index),
        .offset     (offset),
        .wordWrEn   (wordWrEn),
        .wordWrData (wordWrData),
        .tagWrEn    (tagWrEn),
        .newTag     (newTag),
        .setDirty   (setDirty),
        .lineTag    (lineTag),
        .lineValid  (lineValid),
        .lineDirty  (lineDirty),
        .readWord   (readWord)
    );

    mainMemory memory (
        .clk      (clk),
        .reset    (reset),
        .memCyc   (memCyc),
        .memStb   (memStb),
        .memWe    (memWe),
        .memAdr   (memAdr),
        .memDatWr (memDatWr),
        .memDatRd (memDatRd),
        .memAck   (memAck)
    );

endmodule

`default_nettype wire

// File: cacheController_props.sv
// Controller handshake assertions
`default_nettype none

module cacheControllerProps (
    input logic                 clk,
    input logic                 reset,
    input logic                 cyc,
    input logic                 stb,
    input logic                 ack,
    input logic                 memStb,
    input logic                 memAck,
    input cachePkg::addr_t      memAdr,
    input cachePkg::ctrlState_t state,
    input logic                 tagMatch
);
    timeunit 1ns;
    timeprecision 1ps;
    import cachePkg::*;

    // Failures seen so far, read by the testbench
    int failCount = 0;

    // Ack only inside an active cycle
    ackNeedsRequest: assert property (@(posedge clk) disable iff (reset)
        ack |-> (cyc && stb))
        else begin $error("ack without cyc and stb"); failCount++; end

    ackSinglePulse: assert property (@(posedge clk) disable iff (reset)
        ack |=> !ack)
        else begin $error("ack longer than one cycle"); failCount++; end

    // Memory strobe and address held until the slave answers
    memStbHeld: assert property (@(posedge clk) disable iff (reset)
        (memStb && !memAck) |=> (memStb && $stable(memAdr)))
        else begin $error("memStb or memAdr changed before memAck"); failCount++; end

    // Hit: one cycle in Lookup, ack in the next
    hitLatency: assert property (@(posedge clk) disable iff (reset)
        (state == Idle && cyc && stb) ##1 (state == Lookup && tagMatch) |=> ack)
        else begin $error("hit ack not two cycles after accept"); failCount++; end

endmodule

bind cacheController cacheControllerProps props (.*);

`default_nettype wire

// File: instructionL1Tb.sv
// Instruction cache testbench
`default_nettype none

module instructionL1Tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cachePkg::*;

    localparam int directedCount = 7;
    localparam int randomCount   = 200;
    // Dirty eviction plus refill stays well below 40 cycles
    localparam int cycleLimit    = (directedCount + randomCount) * 40 + 100;

    logic  clk;
    logic  reset;
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    word_t datWr;
    word_t datRd;
    logic  ack;
    logic  hit;

    int          errorCount = 0;
    int          cycleCount = 0;
    logic [31:0] lfsrState  = 32'h36ba;

    // Flat memory image plus shadow tags
    word_t refMem [2**addrBits];
    tag_t  shadowTag [2**indexBits];
    logic  shadowValid [2**indexBits];

    // Outstanding requests in issue order
    string       nameQ [$];
    logic        weQ [$];
    logic [16:0] expQ [$];
    int          issueQ [$];

    instructionL1 dut (
        .clk   (clk),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .datWr (datWr),
        .datRd (datRd),
        .ack   (ack),
        .hit   (hit)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles, a request never got its ack", cycleCount);
            $display("Finished with errors");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    // One step per bit taken
    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] bits;
        logic        feedback;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};
            bits      = {bits[30:0], feedback};
        end
        return bits;
    endfunction

    // Only four lines so that tags keep colliding
    function automatic index_t hotIndex(input logic [1:0] sel);
        case (sel)
            2'd0:    return 11'h000;
            2'd1:    return 11'h001;
            2'd2:    return 11'h2a5;
            default: return 11'h7ff;
        endcase
    endfunction

    // Expected {hit, datRd} before the model takes the access
    // Every access leaves its line resident under write-allocate
    function automatic logic [16:0] predict(input logic w, input addr_t a, input word_t d);
        tag_t   t;
        index_t i;
        logic   h;
        word_t  r;
        t = a[15:14];
        i = a[13:3];
        h = shadowValid[i] && (shadowTag[i] == t);
        shadowValid[i] = 1'b1;
        shadowTag[i]   = t;
        r = refMem[a];
        if (w) begin
            refMem[a] = d;
        end
        return {h, r};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            errorCount++;
        end
    endtask

    // One Wishbone request held until ack
    // Entered just after a rising edge
    task automatic access(input string name, input logic w, input addr_t a, input word_t d);
        nameQ.push_back(name);
        weQ.push_back(w);
        expQ.push_back(predict(w, a, d));
        issueQ.push_back(cycleCount);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = w;
        adr   = a;
        datWr = d;
        @(negedge clk);
        while (ack !== 1'b1) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    // Compare every ack against the oldest expectation
    always @(negedge clk) begin
        string       name;
        logic [16:0] expected;
        logic        wasWrite;
        int          issued;
        if (ack === 1'b1) begin
            if (nameQ.size() == 0) begin
                $display("ERROR: ack asserted with no request outstanding");
                errorCount++;
            end else begin
                name     = nameQ.pop_front();
                wasWrite = weQ.pop_front();
                expected = expQ.pop_front();
                issued   = issueQ.pop_front();
                checkValue({name, " hit"}, expected[16], hit);
                if (!wasWrite) begin
                    checkValue({name, " data"}, expected[15:0], datRd);
                end
                // A hit is accepted at the next edge and acked two edges later
                if (expected[16]) begin
                    checkValue({name, " hit latency"}, 2, cycleCount - issued);
                end
            end
        end
    end

    initial begin
        tag_t    t;
        index_t  ix;
        offset_t o;
        word_t   d;
        logic    w;
        clk   = 1'b0;
        reset = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        datWr = '0;
        for (int i = 0; i < 2**addrBits; i++) begin
            refMem[i] = '0;
        end
        for (int i = 0; i < 2**indexBits; i++) begin
            shadowValid[i] = 1'b0;
            shadowTag[i]   = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // Quiet bus right after reset
        repeat (3) begin
            @(negedge clk);
            checkValue("ack idle after reset", 0, ack);
        end
        @(posedge clk);
        #1;

        // Cold miss then a hit in the same line
        access("fresh read", 1'b0, 16'h0123, '0);
        access("same line read", 1'b0, 16'h0125, '0);
        // Write then read back
        access("write", 1'b1, 16'h4567, 16'hbeef);
        access("read after write", 1'b0, 16'h4567, '0);
        // Dirty line pushed out by another tag and brought back
        access("dirty write", 1'b1, 16'h1238, 16'hcafe);
        access("conflict read", 1'b0, 16'h9238, '0);
        access("read after eviction", 1'b0, 16'h1238, '0);

        for (int n = 0; n < randomCount; n++) begin
            w  = 1'(takeBits(1));
            t  = tag_t'(takeBits(2));
            ix = hotIndex(2'(takeBits(2)));
            o  = offset_t'(takeBits(3));
            d  = word_t'(takeBits(16));
            access($sformatf("random %0d", n), w, {t, ix, o}, d);
        end

        // Idle bus to catch a late ack
        repeat (2) @(posedge clk);
        $display("Check errors: %0d, assertion errors: %0d",
                 errorCount, dut.ctrl.props.failCount);
        if (errorCount == 0 && dut.ctrl.props.failCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
cachePkg.sv
mainMemory.sv
cacheStorage.sv
cacheController.sv
instructionL1.sv
cacheController_props.sv
instructionL1Tb.sv

// File: Bender.yml
package:
  name: instruction_l1

sources:
  - cachePkg.sv
  - mainMemory.sv
  - cacheStorage.sv
  - cacheController.sv
  - instructionL1.sv
  - target: simulation
    files:
      - cacheController_props.sv
      - instructionL1Tb.sv
